//--- common/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Cache geometry
`define CACHE_BYTES     1024
`define LINE_BYTES      16
`define WORD_BYTES      4
`define NUM_LINES       (`CACHE_BYTES / `LINE_BYTES)

// Data widths
`define WORD_W          (`WORD_BYTES * 8)
`define LINE_W          (`LINE_BYTES * 8)

// Address fields, word addressed
`define WORD_ADDR_W     30
`define WSEL_W          2
`define INDEX_W         6
`define LINE_ADDR_W     (`WORD_ADDR_W - `WSEL_W)
`define TAG_W           (`LINE_ADDR_W - `INDEX_W)

`define CORE_TAG_W      4

`endif

//--- common/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    typedef struct packed {
        logic [`TAG_W-1:0]       tag;
        logic [`INDEX_W-1:0]     index;
        logic [`WSEL_W-1:0]      wsel;
    } addr_fields_t;

    typedef struct packed {
        logic [`LINE_ADDR_W-1:0] line;
        logic [`WSEL_W-1:0]      wsel;
    } addr_line_t;

    // Lookup view and memory view of one word address
    typedef union packed {
        addr_fields_t f;
        addr_line_t   l;
    } core_addr_u;

    typedef struct packed {
        logic                    rw;
        core_addr_u              addr;
        logic [`WORD_BYTES-1:0]  byteen;
        logic [`WORD_W-1:0]      data;
        logic [`CORE_TAG_W-1:0]  tag;
    } core_req_t;

    typedef struct packed {
        logic [`WORD_W-1:0]      data;
        logic [`CORE_TAG_W-1:0]  tag;
    } core_rsp_t;

    typedef struct packed {
        logic                    rw;
        logic [`LINE_ADDR_W-1:0] addr;
        logic [`LINE_BYTES-1:0]  byteen;
        logic [`LINE_W-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        logic [`LINE_W-1:0]      data;
    } mem_rsp_t;

endpackage

//--- cache/cache_store.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_store import cache_pkg::*; (
    input  logic                    clk,

    input  logic                    rd_en,
    input  logic [`INDEX_W-1:0]     rd_index,
    output logic [`TAG_W-1:0]       rd_tag,
    output logic                    rd_valid,
    output logic [`LINE_W-1:0]      rd_data,

    input  logic                    wr_en,
    input  logic [`INDEX_W-1:0]     wr_index,
    input  logic [`TAG_W-1:0]       wr_tag,
    input  logic [`LINE_BYTES-1:0]  wr_byteen,
    input  logic [`LINE_W-1:0]      wr_data,

    input  logic                    clr_en,
    input  logic [`INDEX_W-1:0]     clr_index
);

    logic [`TAG_W-1:0]      tag_mem [`NUM_LINES];
    logic [`LINE_W-1:0]     data_mem [`NUM_LINES];
    logic [`NUM_LINES-1:0]  valid_bits;

    // Read port returns old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_tag   <= tag_mem[rd_index];
            rd_valid <= valid_bits[rd_index];
            rd_data  <= data_mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (clr_en) begin
            valid_bits[clr_index] <= 1'b0;
        end
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            valid_bits[wr_index] <= 1'b1;
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (wr_byteen[b]) begin
                    data_mem[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- cache/flush_ctrl.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module flush_ctrl import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    output logic                flush_valid,
    output logic [`INDEX_W-1:0] flush_index
);

    // One line per cycle from index zero
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_valid <= 1'b1;
            flush_index <= '0;
        end else if (flush_valid) begin
            flush_index <= flush_index + 1'b1;
            if (flush_index == (`NUM_LINES - 1)) begin
                flush_valid <= 1'b0;
            end
        end
    end

    // Index stays off zero for the rest of the sweep
    flush_no_wrap: assert property (
        @(posedge clk) disable iff (reset)
        flush_valid && !$past(reset) |-> (flush_index != '0)
    ) else $error("flush index wrapped during sweep");

endmodule

//--- cache/cache_bank.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_bank import cache_pkg::*; (
    input  logic                clk,
    input  logic                reset,

    input  logic                flush_valid,
    input  logic [`INDEX_W-1:0] flush_index,

    input  core_req_t           core_req,
    input  logic                core_req_valid,
    output logic                core_req_ready,

    output core_rsp_t           core_rsp,
    output logic                core_rsp_valid,
    input  logic                core_rsp_ready,

    output mem_req_t            buf_req,
    output logic                buf_valid,
    input  logic                buf_ready,

    input  mem_rsp_t            mem_rsp,
    input  logic                mem_rsp_valid,
    output logic                mem_rsp_ready
);

    localparam logic [1:0] ST_IDLE      = 2'd0;
    localparam logic [1:0] ST_WRITE     = 2'd1;
    localparam logic [1:0] ST_FILL_WAIT = 2'd2;

    logic [1:0]             state;
    logic                   s1_valid;
    core_req_t              s1_req;
    logic                   fill_done;
    logic [`WORD_W-1:0]     fill_word;

    logic [`TAG_W-1:0]      rd_tag;
    logic                   rd_valid;
    logic [`LINE_W-1:0]     rd_data;
    logic                   wr_en;
    logic [`INDEX_W-1:0]    wr_index;
    logic [`TAG_W-1:0]      wr_tag;
    logic [`LINE_BYTES-1:0] wr_byteen;
    logic [`LINE_W-1:0]     wr_data;

    logic                   s1_hit, wr_hit, s1_free, rsp_fire, idle_open;
    logic                   read_accept, write_start, miss_req, mem_rsp_fire;
    logic [`LINE_BYTES-1:0] lane_byteen;
    logic [`LINE_W-1:0]     lane_data;

    ///////////////////////////////////////////////////////////////////////
    // Lookup and hit/miss

    assign s1_hit = rd_valid && (rd_tag == s1_req.addr.f.tag);
    assign wr_hit = rd_valid && (rd_tag == core_req.addr.f.tag);

    assign core_rsp_valid = s1_valid && (fill_done || s1_hit);
    assign core_rsp.data  = fill_done ? fill_word
                                      : rd_data[s1_req.addr.f.wsel * `WORD_W +: `WORD_W];
    assign core_rsp.tag   = s1_req.tag;

    assign rsp_fire  = core_rsp_valid && core_rsp_ready;
    assign s1_free   = !s1_valid || rsp_fire;
    assign idle_open = !flush_valid && (state == ST_IDLE) && s1_free && core_req_valid;

    assign read_accept = idle_open && !core_req.rw;
    assign write_start = idle_open && core_req.rw;
    assign miss_req    = (state == ST_IDLE) && s1_valid && !fill_done && !s1_hit;

    // Writes hold the port until the store and buffer take them
    assign core_req_ready = read_accept || ((state == ST_WRITE) && buf_ready);

    ///////////////////////////////////////////////////////////////////////
    // Memory side

    assign lane_byteen = {{(`LINE_BYTES - `WORD_BYTES){1'b0}}, core_req.byteen}
                         << (core_req.addr.f.wsel * `WORD_BYTES);
    assign lane_data   = {(`LINE_W / `WORD_W){core_req.data}};

    assign buf_valid = miss_req || (state == ST_WRITE);

    always_comb begin
        if (state == ST_WRITE) begin
            buf_req.rw     = 1'b1;
            buf_req.addr   = core_req.addr.l.line;
            buf_req.byteen = lane_byteen;
            buf_req.data   = lane_data;
        end else begin
            buf_req.rw     = 1'b0;
            buf_req.addr   = s1_req.addr.l.line;
            buf_req.byteen = '0;
            buf_req.data   = '0;
        end
    end

    assign mem_rsp_ready = (state == ST_FILL_WAIT);
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    // Store write, fill or write hit
    always_comb begin
        if (state == ST_FILL_WAIT) begin
            wr_en     = mem_rsp_fire;
            wr_index  = s1_req.addr.f.index;
            wr_tag    = s1_req.addr.f.tag;
            wr_byteen = '1;
            wr_data   = mem_rsp.data;
        end else begin
            wr_en     = (state == ST_WRITE) && buf_ready && wr_hit;
            wr_index  = core_req.addr.f.index;
            wr_tag    = core_req.addr.f.tag;
            wr_byteen = lane_byteen;
            wr_data   = lane_data;
        end
    end

    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_IDLE;
            s1_valid  <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (miss_req && buf_ready) begin
                        state <= ST_FILL_WAIT;
                    end else if (write_start) begin
                        state <= ST_WRITE;
                    end
                end
                ST_WRITE:     if (buf_ready) state <= ST_IDLE;
                ST_FILL_WAIT: if (mem_rsp_valid) state <= ST_IDLE;
                default:      state <= ST_IDLE;
            endcase
            if (read_accept) begin
                s1_valid <= 1'b1;
            end else if (rsp_fire) begin
                s1_valid <= 1'b0;
            end
            if (mem_rsp_fire) begin
                fill_done <= 1'b1;
            end else if (rsp_fire) begin
                fill_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (read_accept) begin
            s1_req <= core_req;
        end
        if (mem_rsp_fire) begin
            fill_word <= mem_rsp.data[s1_req.addr.f.wsel * `WORD_W +: `WORD_W];
        end
    end

    cache_store store (
        .clk       (clk),
        .rd_en     (idle_open),
        .rd_index  (core_req.addr.f.index),
        .rd_tag    (rd_tag),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .wr_byteen (wr_byteen),
        .wr_data   (wr_data),
        .clr_en    (flush_valid),
        .clr_index (flush_index)
    );

    // Memory answers only the line read in flight
    mem_rsp_expected: assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp_valid |-> (state == ST_FILL_WAIT)
    ) else $error("memory response without outstanding fill");

endmodule

//--- rtl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer import cache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  mem_req_t in,
    input  logic     in_valid,
    output logic     in_ready,
    output mem_req_t out,
    output logic     out_valid,
    input  logic     out_ready
);

    mem_req_t skid;
    logic     skid_valid;

    // Registered, no path from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_valid || out_ready) begin
            out <= skid_valid ? skid : in;
        end else if (in_valid && in_ready) begin
            skid <= in;
        end
    end

    out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out)
    ) else $error("memory request changed while stalled");

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  core_req_t core_req,
    input  logic      core_req_valid,
    output logic      core_req_ready,

    output core_rsp_t core_rsp,
    output logic      core_rsp_valid,
    input  logic      core_rsp_ready,

    output mem_req_t  mem_req,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,

    input  mem_rsp_t  mem_rsp,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready
);

    logic                flush_valid;
    logic [`INDEX_W-1:0] flush_index;
    mem_req_t            buf_req;
    logic                buf_valid;
    logic                buf_ready;

    flush_ctrl flush (
        .clk         (clk),
        .reset       (reset),
        .flush_valid (flush_valid),
        .flush_index (flush_index)
    );

    cache_bank bank (
        .clk            (clk),
        .reset          (reset),
        .flush_valid    (flush_valid),
        .flush_index    (flush_index),
        .core_req       (core_req),
        .core_req_valid (core_req_valid),
        .core_req_ready (core_req_ready),
        .core_rsp       (core_rsp),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp_ready (core_rsp_ready),
        .buf_req        (buf_req),
        .buf_valid      (buf_valid),
        .buf_ready      (buf_ready),
        .mem_rsp        (mem_rsp),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    // Memory request path
    skid_buffer mem_req_buf (
        .clk       (clk),
        .reset     (reset),
        .in        (buf_req),
        .in_valid  (buf_valid),
        .in_ready  (buf_ready),
        .out       (mem_req),
        .out_valid (mem_req_valid),
        .out_ready (mem_req_ready)
    );

endmodule

//--- verif/cache_checker.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_checker import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  core_req_t core_req,
    input  logic      core_req_valid,
    input  logic      core_req_ready,
    input  core_rsp_t core_rsp,
    input  logic      core_rsp_valid,
    input  logic      core_rsp_ready,
    input  mem_req_t  mem_req,
    input  logic      mem_req_valid,
    input  logic      mem_req_ready,
    output int        pass_count,
    output int        err_count,
    output int        pending
);

    localparam int MEM_AW     = 12;
    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int LINE_WORDS = `LINE_BYTES / `WORD_BYTES;

    logic [`WORD_W-1:0]    shadow [MEM_WORDS];
    logic [`TAG_W-1:0]     model_tag [`NUM_LINES];
    logic [`NUM_LINES-1:0] model_valid;
    core_rsp_t             rsp_q [$];
    mem_req_t              mem_q [$];
    logic                  hit_due;
    logic                  sweep_done;
    int                    ready_low;

    function automatic logic [`WORD_W-1:0] word_pattern(input logic [`WORD_ADDR_W-1:0] a);
        return {a, 2'b11} ^ 32'hc3a5_5a3c;
    endfunction

    // Write-through, so a cached word always equals memory
    function automatic logic [`WORD_W-1:0] expected_word(input logic [`WORD_ADDR_W-1:0] a);
        return shadow[a[MEM_AW-1:0]];
    endfunction

    function automatic logic [`WORD_W-1:0] byte_mask(input logic [`WORD_BYTES-1:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp === act) begin
            pass_count++;
        end else begin
            err_count++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("%0t error: %s", $time, what);
    endtask

    initial begin
        pass_count = 0;
        err_count  = 0;
        pending    = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = word_pattern(i[`WORD_ADDR_W-1:0]);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Port watch and compare

    always @(posedge clk) begin : watch
        logic [`WORD_ADDR_W-1:0] a;
        logic [`INDEX_W-1:0]     idx;
        logic [`TAG_W-1:0]       atag;
        logic [`WORD_W-1:0]      m;
        core_rsp_t               exp_rsp;
        mem_req_t                exp_mem;
        if (reset) begin
            model_valid = '0;
            rsp_q.delete();
            mem_q.delete();
            hit_due    = 1'b0;
            sweep_done = 1'b0;
            ready_low  = 0;
        end else begin
            if (!sweep_done) begin
                if (core_req_ready) begin
                    sweep_done = 1'b1;
                    check_value("core_req_ready low cycles", `NUM_LINES, ready_low);
                end else begin
                    ready_low++;
                end
            end
            // Hit answers in the cycle after acceptance
            if (hit_due) begin
                check_value("core_rsp_valid", 1, core_rsp_valid);
                hit_due = 1'b0;
            end
            if (core_rsp_valid && core_rsp_ready) begin
                if (rsp_q.size() == 0) begin
                    report_error("core response with no read outstanding");
                end else begin
                    exp_rsp = rsp_q.pop_front();
                    check_value("core_rsp.data", exp_rsp.data, core_rsp.data);
                    check_value("core_rsp.tag", exp_rsp.tag, core_rsp.tag);
                end
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_q.size() == 0) begin
                    report_error("memory request that no core access called for");
                end else begin
                    exp_mem = mem_q.pop_front();
                    check_value("mem_req.rw", exp_mem.rw, mem_req.rw);
                    check_value("mem_req.addr", exp_mem.addr, mem_req.addr);
                    check_value("mem_req.byteen", exp_mem.byteen, mem_req.byteen);
                    for (int w = 0; w < LINE_WORDS; w++) begin
                        m = byte_mask(exp_mem.byteen[w*`WORD_BYTES +: `WORD_BYTES]);
                        if (m != 0) begin
                            check_value("mem_req.data", exp_mem.data[w*`WORD_W +: `WORD_W] & m,
                                        mem_req.data[w*`WORD_W +: `WORD_W] & m);
                        end
                    end
                end
            end
            if (core_req_valid && core_req_ready) begin
                a    = core_req.addr;
                idx  = a[`WSEL_W +: `INDEX_W];
                atag = a[`WORD_ADDR_W-1 -: `TAG_W];
                exp_mem.rw   = core_req.rw;
                exp_mem.addr = a[`WORD_ADDR_W-1:`WSEL_W];
                exp_mem.byteen = '0;
                exp_mem.data   = '0;
                if (core_req.rw) begin
                    // No allocate, the line model stays as it is
                    exp_mem.byteen[a[`WSEL_W-1:0]*`WORD_BYTES +: `WORD_BYTES] = core_req.byteen;
                    exp_mem.data[a[`WSEL_W-1:0]*`WORD_W +: `WORD_W] = core_req.data;
                    mem_q.push_back(exp_mem);
                    for (int b = 0; b < `WORD_BYTES; b++) begin
                        if (core_req.byteen[b]) begin
                            shadow[a[MEM_AW-1:0]][b*8 +: 8] = core_req.data[b*8 +: 8];
                        end
                    end
                end else begin
                    exp_rsp.data = expected_word(a);
                    exp_rsp.tag  = core_req.tag;
                    rsp_q.push_back(exp_rsp);
                    if (model_valid[idx] && (model_tag[idx] == atag)) begin
                        hit_due = 1'b1;
                    end else begin
                        mem_q.push_back(exp_mem);
                        model_valid[idx] = 1'b1;
                        model_tag[idx]   = atag;
                    end
                end
            end
        end
        pending = rsp_q.size() + mem_q.size();
    end

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps
`include "cache_consts.svh"

module tb_top import cache_pkg::*; ();

    localparam int MEM_AW        = 12;
    localparam int MEM_WORDS     = 1 << MEM_AW;
    localparam int LINE_WORDS    = `LINE_BYTES / `WORD_BYTES;
    localparam int REQ_TIMEOUT   = 500;
    localparam int DRAIN_TIMEOUT = 5000;

    logic                    clk;
    logic                    reset;
    core_req_t               core_req;
    logic                    core_req_valid;
    logic                    core_req_ready;
    core_rsp_t               core_rsp;
    logic                    core_rsp_valid;
    logic                    core_rsp_ready;
    mem_req_t                mem_req;
    logic                    mem_req_valid;
    logic                    mem_req_ready;
    mem_rsp_t                mem_rsp;
    logic                    mem_rsp_valid;
    logic                    mem_rsp_ready;

    logic [`WORD_W-1:0]      mem [MEM_WORDS];
    logic [`LINE_ADDR_W-1:0] rd_q [$];
    integer                  seed = 26;
    logic                    rand_mode = 1'b0;
    bit                      timed_out = 1'b0;
    int                      pass_count;
    int                      err_count;
    int                      pending;
    int                      err_mark = 0;
    int                      test_num = 0;

    cache_top uut (.*);

    cache_checker scoreboard (.*);

    function automatic logic [`WORD_W-1:0] word_pattern(input logic [`WORD_ADDR_W-1:0] a);
        return {a, 2'b11} ^ 32'hc3a5_5a3c;
    endfunction

    function automatic logic [`WORD_ADDR_W-1:0] word_addr(input logic [`TAG_W-1:0] t,
                                                          input logic [`INDEX_W-1:0] i,
                                                          input logic [`WSEL_W-1:0] w);
        return {t, i, w};
    endfunction

    function automatic int mem_index(input logic [`LINE_ADDR_W-1:0] line, input int w);
        return int'(line[MEM_AW-`WSEL_W-1:0]) * LINE_WORDS + w;
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic note_timeout(input string reason);
        $display("%0t timeout: %s", $time, reason);
        timed_out = 1'b1;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_req(input logic rw, input logic [`WORD_ADDR_W-1:0] a,
                            input logic [3:0] be, input logic [31:0] d, input logic [3:0] t);
        bit taken;
        taken           = 1'b0;
        core_req.rw     = rw;
        core_req.addr   = a;
        core_req.byteen = be;
        core_req.data   = d;
        core_req.tag    = t;
        core_req_valid  = 1'b1;
        for (int c = 0; (c < REQ_TIMEOUT) && !timed_out; c++) begin
            @(posedge clk);
            if (core_req_ready) begin
                taken = 1'b1;
                break;
            end
        end
        if (taken) begin
            #1;
        end else if (!timed_out) begin
            note_timeout("core request was never accepted");
        end
    endtask

    task automatic wait_drain();
        bit idle;
        idle           = 1'b0;
        core_req_valid = 1'b0;
        for (int c = 0; (c < DRAIN_TIMEOUT) && !timed_out; c++) begin
            @(posedge clk);
            #1;
            if ((pending == 0) && (rd_q.size() == 0)) begin
                idle = 1'b1;
                break;
            end
        end
        if (!idle && !timed_out) begin
            note_timeout("expected responses or memory requests never arrived");
        end
    endtask

    task automatic end_test(input string name);
        wait_drain();
        if (!timed_out) begin
            test_num++;
            if (err_count == err_mark) begin
                $display("test %0d %s: ok", test_num, name);
            end else begin
                $display("test %0d %s: %0d errors", test_num, name, err_count - err_mark);
            end
            err_mark = err_count;
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // Memory model

    always @(posedge clk) begin : mem_accept
        if (!reset && mem_req_valid && mem_req_ready) begin
            if (mem_req.rw) begin
                for (int w = 0; w < LINE_WORDS; w++) begin
                    for (int b = 0; b < `WORD_BYTES; b++) begin
                        if (mem_req.byteen[w*`WORD_BYTES + b]) begin
                            mem[mem_index(mem_req.addr, w)][b*8 +: 8] =
                                mem_req.data[w*`WORD_W + b*8 +: 8];
                        end
                    end
                end
            end else begin
                rd_q.push_back(mem_req.addr);
            end
        end
    end

    initial begin : mem_responder
        logic [`LINE_ADDR_W-1:0] line;
        logic [31:0]             r;
        bit                      taken;
        forever begin
            @(posedge clk);
            #1;
            if (rd_q.size() > 0) begin
                line = rd_q.pop_front();
                r    = $random(seed);
                for (int d = 0; d < int'(r[1:0]); d++) begin
                    @(posedge clk);
                    #1;
                end
                for (int w = 0; w < LINE_WORDS; w++) begin
                    mem_rsp.data[w*`WORD_W +: `WORD_W] = mem[mem_index(line, w)];
                end
                mem_rsp_valid = 1'b1;
                taken         = 1'b0;
                for (int c = 0; (c < REQ_TIMEOUT) && !timed_out; c++) begin
                    @(posedge clk);
                    if (mem_rsp_ready) begin
                        taken = 1'b1;
                        break;
                    end
                end
                if (!taken && !timed_out) begin
                    note_timeout("line fill response was never taken");
                end
                #1;
                mem_rsp_valid = 1'b0;
            end
        end
    end

    // Back-pressure only in the random phase
    initial begin : ready_driver
        logic [31:0] r;
        core_rsp_ready = 1'b1;
        mem_req_ready  = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            core_rsp_ready = !rand_mode || (r[1:0] != 2'b00);
            mem_req_ready  = !rand_mode || (r[3:2] != 2'b00);
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        logic [31:0] r;
        reset          = 1'b1;
        core_req       = '0;
        core_req_valid = 1'b0;
        mem_rsp        = '0;
        mem_rsp_valid  = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = word_pattern(i[`WORD_ADDR_W-1:0]);
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        send_req(1'b0, word_addr(1, 3, 2), 4'h0, 32'h0, 4'h1);
        end_test("flush sweep and first miss");

        send_req(1'b0, word_addr(1, 3, 0), 4'h0, 32'h0, 4'h2);
        send_req(1'b0, word_addr(1, 3, 3), 4'h0, 32'h0, 4'h3);
        end_test("read hits with core tag");

        // A write hit and then a write miss
        send_req(1'b1, word_addr(1, 3, 1), 4'b0110, 32'hdead_beef, 4'h4);
        send_req(1'b1, word_addr(2, 5, 3), 4'b1001, 32'h1234_5678, 4'h5);
        send_req(1'b0, word_addr(1, 3, 1), 4'h0, 32'h0, 4'h6);
        send_req(1'b0, word_addr(2, 5, 3), 4'h0, 32'h0, 4'h7);
        end_test("partial writes and merged reads");

        for (int k = 0; k < 4; k++) begin
            send_req(1'b0, word_addr(4 + (k % 2), 9, k[1:0]), 4'h0, 32'h0, k[3:0]);
        end
        end_test("same index eviction");

        rand_mode = 1'b1;
        for (int k = 0; k < 200; k++) begin
            r = $random(seed);
            send_req(r[13:12] == 2'b00, word_addr(r[9:8], r[4:2], r[1:0]), r[19:16],
                     $random(seed), r[23:20]);
        end
        end_test("random traffic with back-pressure");
        rand_mode = 1'b0;

        $display("checks: %0d passed, %0d failed", pass_count, err_count);
        if ((err_count == 0) && !timed_out) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+common
common/cache_pkg.sv
cache/cache_store.sv
cache/flush_ctrl.sv
cache/cache_bank.sv
rtl/skid_buffer.sv
rtl/cache_top.sv
verif/cache_checker.sv
verif/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
